/* hdl/cpu_cfg.svh */
// Widths and fixed addresses shared by the core, the bridge and the checker
// Operand is zero-extended, so data addresses stay below 2^28
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data, address and instruction width
`define CPU_WORD_BITS 32

`define CPU_OPCODE_BITS 4    // Top bits of an instruction
`define CPU_OPERAND_BITS 28  // Low bits, zero-extended to a word

// Address bit of the pin frame that marks a write
`define BUS_WRITE_BIT 31

`define CPU_RESET_PC 32'h0000_0000

`endif

/* hdl/cpu_core.sv */
// Accumulator core with one outstanding bus access at a time
// Request signals are held from bus_req rising until bus_done
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bus_done,
  input  logic [`CPU_WORD_BITS-1:0] bus_rdata,
  output logic                      bus_req,
  output logic                      bus_we,
  output logic [`CPU_WORD_BITS-1:0] bus_addr,
  output logic [`CPU_WORD_BITS-1:0] bus_wdata
);

  cpu_isa_pkg::cpu_state_t   state;
  cpu_isa_pkg::opcode_t      opcode;
  logic [`CPU_WORD_BITS-1:0] pc;
  logic [`CPU_WORD_BITS-1:0] acc;
  logic [`CPU_WORD_BITS-1:0] instr;    // Latched at the end of the fetch
  logic [`CPU_WORD_BITS-1:0] operand;
  logic [`CPU_WORD_BITS-1:0] pc_seq;   // Fall-through address

  // Decode fields of the latched instruction
  assign opcode  = cpu_isa_pkg::opcode_t'(instr[`CPU_WORD_BITS-1 -: `CPU_OPCODE_BITS]);
  assign operand = {{(`CPU_WORD_BITS-`CPU_OPERAND_BITS){1'b0}},
                    instr[`CPU_OPERAND_BITS-1:0]};
  assign pc_seq  = pc + 4;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= cpu_isa_pkg::FETCH;
      pc        <= `CPU_RESET_PC;
      acc       <= '0;
      instr     <= '0;
      bus_req   <= 1'b0;
      bus_we    <= 1'b0;
      bus_addr  <= '0;
      bus_wdata <= '0;
    end
    else
    begin
      case (state)
        cpu_isa_pkg::FETCH:
        begin
          if (bus_done)
          begin
            instr   <= bus_rdata;
            bus_req <= 1'b0;
            state   <= cpu_isa_pkg::EXECUTE;
          end
          else
          begin
            // Instruction read at PC, stable until done
            bus_req   <= 1'b1;
            bus_we    <= 1'b0;
            bus_addr  <= pc;
            bus_wdata <= '0;
          end
        end

        cpu_isa_pkg::EXECUTE:
        begin
          case (opcode)
            cpu_isa_pkg::LDI:
            begin
              acc   <= operand;
              pc    <= pc_seq;
              state <= cpu_isa_pkg::FETCH;
            end
            cpu_isa_pkg::LD, cpu_isa_pkg::ADD, cpu_isa_pkg::SUB:
            begin
              // Operand word comes from memory
              bus_req   <= 1'b1;
              bus_we    <= 1'b0;
              bus_addr  <= operand;
              bus_wdata <= '0;
              state     <= cpu_isa_pkg::MEMORY;
            end
            cpu_isa_pkg::ST:
            begin
              bus_req   <= 1'b1;
              bus_we    <= 1'b1;
              bus_addr  <= operand;
              bus_wdata <= acc;
              state     <= cpu_isa_pkg::MEMORY;
            end
            cpu_isa_pkg::JMP:
            begin
              pc    <= operand;
              state <= cpu_isa_pkg::FETCH;
            end
            cpu_isa_pkg::JZ:
            begin
              pc    <= (acc == '0) ? operand : pc_seq;
              state <= cpu_isa_pkg::FETCH;
            end
            cpu_isa_pkg::HALT:
              state <= cpu_isa_pkg::HALTED;
            cpu_isa_pkg::NOP:
            begin
              pc    <= pc_seq;
              state <= cpu_isa_pkg::FETCH;
            end
            default:
            begin
              pc    <= pc_seq;  // Unassigned codes act as NOP
              state <= cpu_isa_pkg::FETCH;
            end
          endcase
        end

        cpu_isa_pkg::MEMORY:
        begin
          if (bus_done)
          begin
            case (opcode)
              cpu_isa_pkg::LD:  acc <= bus_rdata;
              cpu_isa_pkg::ADD: acc <= acc + bus_rdata;  // Wraps mod 2^32
              cpu_isa_pkg::SUB: acc <= acc - bus_rdata;
              default:          acc <= acc;              // ST leaves acc alone
            endcase
            bus_req <= 1'b0;
            bus_we  <= 1'b0;
            pc      <= pc_seq;
            state   <= cpu_isa_pkg::FETCH;
          end
        end

        cpu_isa_pkg::HALTED:
          state <= cpu_isa_pkg::HALTED;

        default:
          state <= cpu_isa_pkg::FETCH;
      endcase
    end
  end

endmodule

/* hdl/cpu_isa_pkg.sv */
// Instruction set and core sequencing states of the accumulator CPU
// Opcodes not listed here execute as NOP
`include "cpu_cfg.svh"

package cpu_isa_pkg;

  // Opcode field in the top bits of each instruction word
  typedef enum logic [`CPU_OPCODE_BITS-1:0] {
    NOP  = 4'd0,
    LDI  = 4'd1,  // acc = operand
    LD   = 4'd2,  // acc = mem[operand]
    ST   = 4'd3,  // mem[operand] = acc
    ADD  = 4'd4,  // acc += mem[operand]
    SUB  = 4'd5,  // acc -= mem[operand]
    JMP  = 4'd6,
    JZ   = 4'd7,  // Jump when acc is zero
    HALT = 4'd8
  } opcode_t;

  // One instruction walks FETCH, EXECUTE and optionally MEMORY
  typedef enum logic [1:0] {
    FETCH   = 2'd0,
    EXECUTE = 2'd1,
    MEMORY  = 2'd2,
    HALTED  = 2'd3   // Left only by reset
  } cpu_state_t;

endpackage

/* hdl/pin_bus_bridge.sv */
// Serializes one core access into an eight-phase byte frame, little-endian
// mem_wait repeats the current IN phase; write frames still run all IN phases
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module pin_bus_bridge (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bus_req,
  input  logic                      bus_we,
  input  logic [`CPU_WORD_BITS-1:0] bus_addr,
  input  logic [`CPU_WORD_BITS-1:0] bus_wdata,
  input  logic [7:0]                uio_in,
  input  logic                      mem_wait,
  output logic                      bus_done,
  output logic [`CPU_WORD_BITS-1:0] bus_rdata,
  output logic [7:0]                uo_out,
  output logic [7:0]                uio_out,
  output logic [7:0]                uio_oe
);

  pin_bus_pkg::bus_phase_t   phase;
  pin_bus_pkg::bus_phase_t   phase_next;
  logic [`CPU_WORD_BITS-1:0] frame_addr;  // Address with write flag folded in
  logic                      drive_next;  // Next phase is an OUT phase
  logic [1:0]                byte_next;
  logic                      sample;

  always_comb
  begin
    frame_addr = bus_addr;
    frame_addr[`BUS_WRITE_BIT] = bus_we;
  end

  always_comb
  begin
    case (phase)
      pin_bus_pkg::IDLE: phase_next = bus_req ? pin_bus_pkg::OUT0 : pin_bus_pkg::IDLE;
      pin_bus_pkg::OUT0: phase_next = pin_bus_pkg::OUT1;
      pin_bus_pkg::OUT1: phase_next = pin_bus_pkg::OUT2;
      pin_bus_pkg::OUT2: phase_next = pin_bus_pkg::OUT3;
      pin_bus_pkg::OUT3: phase_next = pin_bus_pkg::IN0;
      pin_bus_pkg::IN0:  phase_next = mem_wait ? pin_bus_pkg::IN0 : pin_bus_pkg::IN1;
      pin_bus_pkg::IN1:  phase_next = mem_wait ? pin_bus_pkg::IN1 : pin_bus_pkg::IN2;
      pin_bus_pkg::IN2:  phase_next = mem_wait ? pin_bus_pkg::IN2 : pin_bus_pkg::IN3;
      pin_bus_pkg::IN3:  phase_next = mem_wait ? pin_bus_pkg::IN3 : pin_bus_pkg::DONE;
      default:           phase_next = pin_bus_pkg::IDLE;  // DONE and stray codes
    endcase
  end

  // Byte lane for the pins in the coming phase
  always_comb
  begin
    drive_next = 1'b1;
    case (phase_next)
      pin_bus_pkg::OUT0: byte_next = 2'd0;
      pin_bus_pkg::OUT1: byte_next = 2'd1;
      pin_bus_pkg::OUT2: byte_next = 2'd2;
      pin_bus_pkg::OUT3: byte_next = 2'd3;
      default:
      begin
        drive_next = 1'b0;
        byte_next  = 2'd0;
      end
    endcase
  end

  // A byte is taken at the edge that ends an IN phase without wait
  assign sample = (phase inside {pin_bus_pkg::IN0, pin_bus_pkg::IN1,
                                 pin_bus_pkg::IN2, pin_bus_pkg::IN3}) && !mem_wait;

  assign bus_done = (phase == pin_bus_pkg::DONE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase   <= pin_bus_pkg::IDLE;
      uo_out  <= 8'h00;
      uio_out <= 8'h00;
      uio_oe  <= 8'h00;
    end
    else
    begin
      phase   <= phase_next;
      uo_out  <= drive_next ? frame_addr[8*byte_next +: 8] : 8'h00;
      uio_out <= (drive_next && bus_we) ? bus_wdata[8*byte_next +: 8] : 8'h00;
      uio_oe  <= drive_next ? 8'hFF : 8'h00;  // Pins turn around after OUT3
    end
  end

  // Byte 0 arrives first and ends up in the low lane
  always_ff @(posedge clk)
  begin
    if (sample)
      bus_rdata <= {uio_in, bus_rdata[`CPU_WORD_BITS-1:8]};
  end

endmodule

/* hdl/pin_bus_pkg.sv */
// Phases of the eight-phase byte frame on the tile pins
// OUT phases drive the pins, IN phases sample uio_in
package pin_bus_pkg;

  typedef enum logic [3:0] {
    IDLE = 4'd0,
    OUT0 = 4'd1,  // Address and write-data byte 0
    OUT1 = 4'd2,
    OUT2 = 4'd3,
    OUT3 = 4'd4,
    IN0  = 4'd5,  // Read-data byte 0, may repeat on wait
    IN1  = 4'd6,
    IN2  = 4'd7,
    IN3  = 4'd8,
    DONE = 4'd9   // bus_done pulse
  } bus_phase_t;

endpackage

/* hdl/tt_um_cpu_handler.sv */
// Tile top: accumulator CPU behind the eight-phase pin bus
// ui_in[0] is the memory wait input, other ui_in bits and ena are ignored
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tt_um_cpu_handler (
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,   // All ones while the frame drives the pins
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  logic                      bus_req;
  logic                      bus_we;
  logic                      bus_done;
  logic [`CPU_WORD_BITS-1:0] bus_addr;
  logic [`CPU_WORD_BITS-1:0] bus_wdata;
  logic [`CPU_WORD_BITS-1:0] bus_rdata;
  logic                      unused_inputs;

  cpu_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_done  (bus_done),
    .bus_rdata (bus_rdata),
    .bus_req   (bus_req),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata)
  );

  pin_bus_bridge u_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .uio_in    (uio_in),
    .mem_wait  (ui_in[0]),
    .bus_done  (bus_done),
    .bus_rdata (bus_rdata),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe)
  );

  // Tile inputs with no function in this design
  assign unused_inputs = &{ena, ui_in[7:1], 1'b0};

endmodule

/* sim.f */
+incdir+hdl
hdl/cpu_isa_pkg.sv
hdl/pin_bus_pkg.sv
hdl/cpu_core.sv
hdl/pin_bus_bridge.sv
hdl/tt_um_cpu_handler.sv
testbench/cpu_handler_properties.sv
testbench/cpu_handler_checker.sv
testbench/tb_cpu_handler.sv

/* testbench/cpu_handler_checker.sv */
// Rebuilds each pin frame and compares it with a reference model of the core
// Memory image must arrive through preload_word before reset is released
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_handler_checker (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] uo_out,
  input  logic [7:0] uio_out,
  input  logic [7:0] uio_oe,
  output int         value_errors,
  output int         protocol_errors,
  output int         frames_seen,
  output logic       halt_seen
);

  logic [`CPU_WORD_BITS-1:0] model_mem [logic [`CPU_WORD_BITS-1:0]];
  logic [`CPU_WORD_BITS-1:0] model_pc;
  logic [`CPU_WORD_BITS-1:0] model_acc;
  logic                      model_halted;
  logic [`CPU_WORD_BITS-1:0] exp_addr [$];   // Expected accesses with the oldest first
  logic                      exp_we [$];
  logic [`CPU_WORD_BITS-1:0] exp_wdata [$];
  logic [`CPU_WORD_BITS-1:0] got_addr;
  logic [`CPU_WORD_BITS-1:0] got_wdata;
  int                        out_cnt;

  initial
  begin
    value_errors    = 0;
    protocol_errors = 0;
    frames_seen     = 0;
    halt_seen       = 1'b0;
    model_pc        = `CPU_RESET_PC;
    model_acc       = '0;
    model_halted    = 1'b0;
    out_cnt         = 0;
  end

  task automatic preload_word(input logic [31:0] addr, input logic [31:0] data);
    model_mem[addr] = data;
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (model_mem.exists(addr))
      return model_mem[addr];
    return '0;
  endfunction

  function automatic void push_access(input logic [31:0] addr, input logic we,
                                      input logic [31:0] wdata);
    exp_addr.push_back(addr);
    exp_we.push_back(we);
    exp_wdata.push_back(wdata);
  endfunction

  // Runs one instruction on the model and queues the accesses it makes
  function automatic void step_reference();
    logic [31:0]          instr;
    logic [31:0]          operand;
    logic [31:0]          next_pc;
    cpu_isa_pkg::opcode_t op;
    instr   = model_read(model_pc);
    op      = cpu_isa_pkg::opcode_t'(instr[31 -: `CPU_OPCODE_BITS]);
    operand = {{(32-`CPU_OPERAND_BITS){1'b0}}, instr[`CPU_OPERAND_BITS-1:0]};
    next_pc = model_pc + 4;
    push_access(model_pc, 1'b0, '0);          // Instruction fetch
    case (op)
      cpu_isa_pkg::LDI: model_acc = operand;
      cpu_isa_pkg::LD:
      begin
        push_access(operand, 1'b0, '0);
        model_acc = model_read(operand);
      end
      cpu_isa_pkg::ST:
      begin
        push_access(operand, 1'b1, model_acc);
        model_mem[operand] = model_acc;
      end
      cpu_isa_pkg::ADD:
      begin
        push_access(operand, 1'b0, '0);
        model_acc = model_acc + model_read(operand);
      end
      cpu_isa_pkg::SUB:
      begin
        push_access(operand, 1'b0, '0);
        model_acc = model_acc - model_read(operand);
      end
      cpu_isa_pkg::JMP: next_pc = operand;
      cpu_isa_pkg::JZ:  next_pc = (model_acc == '0) ? operand : next_pc;
      cpu_isa_pkg::HALT: model_halted = 1'b1;
      default: ;                                // NOP and unused codes
    endcase
    model_pc = next_pc;
  endfunction

  task automatic check_frame();
    logic [31:0] want_addr;
    logic        want_we;
    logic [31:0] want_wdata;
    logic [31:0] addr_bits;
    if (exp_addr.size() == 0 && !model_halted)
      step_reference();
    frames_seen++;
    if (exp_addr.size() == 0)
    begin
      protocol_errors++;
      $display("Error at %0t: a frame to %h appeared after the HALT fetch", $time, got_addr);
    end
    else
    begin
      want_addr  = exp_addr.pop_front();
      want_we    = exp_we.pop_front();
      want_wdata = exp_wdata.pop_front();
      addr_bits  = got_addr;
      addr_bits[`BUS_WRITE_BIT] = 1'b0;
      if (addr_bits !== want_addr)
      begin
        value_errors++;
        $display("FAILED at %0t: uo_out address expected %h, got %h",
                 $time, want_addr, addr_bits);
      end
      if (got_addr[`BUS_WRITE_BIT] !== want_we)
      begin
        value_errors++;
        $display("FAILED at %0t: uo_out write flag expected %b, got %b",
                 $time, want_we, got_addr[`BUS_WRITE_BIT]);
      end
      if (got_wdata !== want_wdata)
      begin
        value_errors++;
        $display("FAILED at %0t: uio_out write data expected %h, got %h",
                 $time, want_wdata, got_wdata);
      end
      if (model_halted && exp_addr.size() == 0)
        halt_seen = 1'b1;                       // HALT fetch has gone out
    end
  endtask

  // Pins are sampled before the edge updates them
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (uo_out !== 8'h00 || uio_out !== 8'h00 || uio_oe !== 8'h00)
      begin
        value_errors++;
        $display("FAILED at %0t: reset uo_out/uio_out/uio_oe expected 00/00/00, got %h/%h/%h",
                 $time, uo_out, uio_out, uio_oe);
      end
      out_cnt = 0;
    end
    else if (uio_oe === 8'hFF)
    begin
      if (out_cnt == 4)
      begin
        protocol_errors++;
        $display("Error at %0t: uio_oe stayed high past the fourth byte", $time);
      end
      else
      begin
        got_addr[8*out_cnt +: 8]  = uo_out;   // Little-endian byte lanes
        got_wdata[8*out_cnt +: 8] = uio_out;
        out_cnt++;
        if (out_cnt == 4)
          check_frame();
      end
    end
    else
    begin
      if (uio_oe !== 8'h00)
      begin
        value_errors++;
        $display("FAILED at %0t: uio_oe expected 00 or ff, got %h", $time, uio_oe);
      end
      if (uo_out !== 8'h00 || uio_out !== 8'h00)
      begin
        value_errors++;
        $display("FAILED at %0t: uo_out/uio_out expected 00/00, got %h/%h",
                 $time, uo_out, uio_out);
      end
      out_cnt = 0;
    end
  end

endmodule

/* testbench/cpu_handler_properties.sv */
// Bound into pin_bus_bridge, reads its phase register and wait input
`timescale 1ns/1ps

module cpu_handler_properties (
  input logic                    clk,
  input logic                    rst_n,
  input pin_bus_pkg::bus_phase_t phase,
  input logic                    mem_wait,
  input logic                    bus_done,
  input logic [7:0]              uo_out,
  input logic [7:0]              uio_out,
  input logic [7:0]              uio_oe
);

  int   fail_count = 0;
  logic in_phase;

  assign in_phase = phase inside {pin_bus_pkg::IN0, pin_bus_pkg::IN1,
                                  pin_bus_pkg::IN2, pin_bus_pkg::IN3};

  // Pins are either all driven or all released
  oe_levels: assert property (@(posedge clk) disable iff (!rst_n)
    uio_oe == 8'h00 || uio_oe == 8'hFF)
  else
  begin
    fail_count++;
    $error("uio_oe is neither 00 nor FF");
  end

  done_after_in3: assert property (@(posedge clk) disable iff (!rst_n)
    bus_done |-> $past(phase) == pin_bus_pkg::IN3 && !$past(mem_wait))
  else
  begin
    fail_count++;
    $error("bus_done does not follow a completed IN3 phase");
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    bus_done |=> !bus_done)
  else
  begin
    fail_count++;
    $error("bus_done lasts more than one cycle");
  end

  wait_holds_phase: assert property (@(posedge clk) disable iff (!rst_n)
    in_phase && mem_wait |=> phase == $past(phase))
  else
  begin
    fail_count++;
    $error("IN phase advanced while mem_wait was high");
  end

  idle_pins_zero: assert property (@(posedge clk) disable iff (!rst_n)
    phase == pin_bus_pkg::IDLE |-> uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == 8'h00)
  else
  begin
    fail_count++;
    $error("Pins are not zero in IDLE");
  end

endmodule

/* testbench/tb_cpu_handler.sv */
// Top testbench with clock, reset, pin-level memory model and watchdog
// Memory waits last at most MAX_WAITS cycles in a row per IN phase
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_handler;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 4;
  localparam int MAX_WAITS      = 3;
  localparam int FRAME_WORST    = 4 + 4 * (1 + MAX_WAITS) + 4;  // Includes request, done and idle
  localparam int PROGRAM_INSTRS = 27;   // Executed instructions up to HALT
  localparam int QUIET_CYCLES   = 100;  // Watched after the HALT fetch
  localparam int WATCHDOG_NS    = CLK_PERIOD * (RESET_CYCLES + QUIET_CYCLES + 200
                                                + PROGRAM_INSTRS * 2 * FRAME_WORST);

  logic        clk;
  logic        rst_n;
  logic        ena;
  logic [7:0]  ui_in;
  logic [7:0]  uio_in;
  logic [7:0]  uo_out;
  logic [7:0]  uio_out;
  logic [7:0]  uio_oe;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] frame_addr;
  logic [31:0] frame_wdata;
  logic [31:0] word_addr;
  logic [31:0] rd_word;
  logic        in_active;
  int          out_cnt;
  int          in_idx;
  int          wait_run;
  int          value_errors;
  int          protocol_errors;
  int          frames_seen;
  int          assert_errors;
  logic        halt_seen;

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  tt_um_cpu_handler DUT (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  cpu_handler_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .uo_out          (uo_out),
    .uio_out         (uio_out),
    .uio_oe          (uio_oe),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .frames_seen     (frames_seen),
    .halt_seen       (halt_seen)
  );

  bind pin_bus_bridge cpu_handler_properties u_props (
    .clk (clk), .rst_n (rst_n), .phase (phase), .mem_wait (mem_wait),
    .bus_done (bus_done), .uo_out (uo_out), .uio_out (uio_out), .uio_oe (uio_oe)
  );

  assign assert_errors = DUT.u_bridge.u_props.fail_count;

  function automatic logic [31:0] encode(input cpu_isa_pkg::opcode_t op,
                                         input logic [31:0] operand);
    return {op, operand[`CPU_OPERAND_BITS-1:0]};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return '0;
  endfunction

  // Wait roughly one cycle in four and never more than MAX_WAITS in a row
  function automatic logic next_wait();
    int unsigned draw;
    logic        w;
    draw     = $urandom;
    w        = (wait_run < MAX_WAITS) && (draw % 4 == 0);
    wait_run = w ? wait_run + 1 : 0;
    return w;
  endfunction

  task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr] = data;
    u_checker.preload_word(addr, data);
  endtask

  task automatic load_program();
    put_word(32'h00, encode(cpu_isa_pkg::LD,   32'h100));
    put_word(32'h04, encode(cpu_isa_pkg::ADD,  32'h104));
    put_word(32'h08, encode(cpu_isa_pkg::ST,   32'h200));
    put_word(32'h0C, encode(cpu_isa_pkg::SUB,  32'h108));
    put_word(32'h10, encode(cpu_isa_pkg::ST,   32'h204));
    put_word(32'h14, encode(cpu_isa_pkg::LDI,  32'h0FFF_FFFF));
    put_word(32'h18, encode(cpu_isa_pkg::ADD,  32'h10C));  // Carries out of bit 31
    put_word(32'h1C, encode(cpu_isa_pkg::SUB,  32'h114));  // Borrows below zero
    put_word(32'h20, encode(cpu_isa_pkg::ST,   32'h208));
    put_word(32'h24, encode(cpu_isa_pkg::LDI,  32'd3));    // Loop count
    put_word(32'h28, encode(cpu_isa_pkg::ST,   32'h20C));
    put_word(32'h2C, encode(cpu_isa_pkg::LD,   32'h20C));  // Loop head
    put_word(32'h30, encode(cpu_isa_pkg::SUB,  32'h110));
    put_word(32'h34, encode(cpu_isa_pkg::ST,   32'h20C));
    put_word(32'h38, encode(cpu_isa_pkg::JZ,   32'h40));
    put_word(32'h3C, encode(cpu_isa_pkg::JMP,  32'h2C));
    put_word(32'h40, encode(cpu_isa_pkg::ST,   32'h210));
    put_word(32'h44, encode(cpu_isa_pkg::HALT, 32'h0));
    put_word(32'h100, $urandom);
    put_word(32'h104, $urandom);
    put_word(32'h108, $urandom);
    put_word(32'h10C, 32'hF000_0005);
    put_word(32'h110, 32'd1);
    put_word(32'h114, 32'd5);
  endtask

  // Memory model sees each pin value before the edge replaces it
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_cnt   = 0;
      in_active = 1'b0;
      wait_run  = 0;
      uio_in <= 8'h00;
      ui_in  <= 8'h00;
    end
    else if (uio_oe == 8'hFF)
    begin
      frame_addr[8*out_cnt +: 8]  = uo_out;
      frame_wdata[8*out_cnt +: 8] = uio_out;
      out_cnt++;
      if (out_cnt == 4)
      begin
        word_addr = frame_addr;                  // Bridge enters IN0 at this edge
        word_addr[`BUS_WRITE_BIT] = 1'b0;
        if (frame_addr[`BUS_WRITE_BIT])
        begin
          mem[word_addr] = frame_wdata;
          rd_word = '0;
        end
        else
          rd_word = read_word(word_addr);
        out_cnt   = 0;
        in_idx    = 0;
        in_active = 1'b1;
        uio_in <= rd_word[7:0];
        ui_in  <= {7'b0, next_wait()};
      end
    end
    else if (in_active)
    begin
      if (ui_in[0])
        ui_in <= {7'b0, next_wait()};            // Phase repeats and the byte stays
      else if (in_idx == 3)
      begin
        in_active = 1'b0;
        uio_in <= 8'h00;
        ui_in  <= 8'h00;
      end
      else
      begin
        in_idx++;
        uio_in <= rd_word[8*in_idx +: 8];
        ui_in  <= {7'b0, next_wait()};
      end
    end
  end

  initial
  begin
    void'($urandom(32'h6740c562));
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    rst_n  = 1'b0;
    load_program();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    wait (halt_seen === 1'b1);
    repeat (QUIET_CYCLES) @(posedge clk);  // No frame may follow HALT
    $display("Error counts: %0d value, %0d protocol, %0d assertion, %0d frames checked",
             value_errors, protocol_errors, assert_errors, frames_seen);
    if (value_errors + protocol_errors + assert_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the program did not reach HALT within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
